//--- src.f
source/axi_pkg.sv
source/xbar_pkg.sv
source/axi_wr_if.sv
source/wr_arbiter.sv
source/wr_channel_ctrl.sv
source/master_wr_mux.sv
source/slave_wr_router.sv
source/axi_lite_wr_xbar.sv
verification/xbar_assertions.sv
verification/tb_axi_lite_wr_xbar.sv

//--- run.sh
#!/bin/bash
# Build and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_axi_lite_wr_xbar \
	-o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error status"

grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log && echo "simulation passed" || { echo "no result in sim.log"; exit 1; }

//--- verification/tb_axi_lite_wr_xbar.sv
`timescale 1ns/1ps

module tb_axi_lite_wr_xbar;

	logic ACLK;
	logic ARESETn;

	logic           m_awvalid [xbar_pkg::N_MASTERS];
	logic           m_awready [xbar_pkg::N_MASTERS];
	axi_pkg::addr_t m_awaddr [xbar_pkg::N_MASTERS];
	logic           m_wvalid [xbar_pkg::N_MASTERS];
	logic           m_wready [xbar_pkg::N_MASTERS];
	axi_pkg::data_t m_wdata [xbar_pkg::N_MASTERS];
	axi_pkg::strb_t m_wstrb [xbar_pkg::N_MASTERS];
	logic           m_bvalid [xbar_pkg::N_MASTERS];
	logic           m_bready [xbar_pkg::N_MASTERS];
	axi_pkg::resp_e m_bresp [xbar_pkg::N_MASTERS];

	logic           s_awvalid [xbar_pkg::N_SLAVES];
	logic           s_awready [xbar_pkg::N_SLAVES];
	axi_pkg::addr_t s_awaddr [xbar_pkg::N_SLAVES];
	logic           s_wvalid [xbar_pkg::N_SLAVES];
	logic           s_wready [xbar_pkg::N_SLAVES];
	axi_pkg::data_t s_wdata [xbar_pkg::N_SLAVES];
	axi_pkg::strb_t s_wstrb [xbar_pkg::N_SLAVES];
	logic           s_bvalid [xbar_pkg::N_SLAVES];
	logic           s_bready [xbar_pkg::N_SLAVES];
	axi_pkg::resp_e s_bresp [xbar_pkg::N_SLAVES];

	// Mid-cycle samples and scoreboard state
	logic           m_aw_hs [xbar_pkg::N_MASTERS];
	logic           m_w_hs [xbar_pkg::N_MASTERS];
	logic           m_b_hs [xbar_pkg::N_MASTERS];
	logic           done [xbar_pkg::N_MASTERS];
	logic           bvalid_seen [xbar_pkg::N_MASTERS];
	logic           awready_seen [xbar_pkg::N_MASTERS];
	logic           wready_seen [xbar_pkg::N_MASTERS];
	axi_pkg::resp_e got_resp [xbar_pkg::N_MASTERS];
	logic           aw_seen [xbar_pkg::N_SLAVES];
	logic           w_seen [xbar_pkg::N_SLAVES];
	logic           s_aw_hs [xbar_pkg::N_SLAVES];
	logic           s_w_hs [xbar_pkg::N_SLAVES];
	logic           s_b_hs [xbar_pkg::N_SLAVES];
	logic           b_pend [xbar_pkg::N_SLAVES];
	logic           hold_b [xbar_pkg::N_SLAVES];
	int             aw_cnt [xbar_pkg::N_SLAVES];
	int             w_cnt [xbar_pkg::N_SLAVES];
	int             b_cnt [xbar_pkg::N_SLAVES];
	axi_pkg::addr_t got_addr [xbar_pkg::N_SLAVES];
	axi_pkg::data_t got_data [xbar_pkg::N_SLAVES];
	axi_pkg::strb_t got_strb [xbar_pkg::N_SLAVES];
	int             b_order [$];

	int checks;
	int errors;
	integer seed;

	axi_lite_wr_xbar uut (
		.ACLK (ACLK), .ARESETn (ARESETn),
		.m0_awvalid_i (m_awvalid[0]), .m1_awvalid_i (m_awvalid[1]), .m2_awvalid_i (m_awvalid[2]),
		.m0_awready_o (m_awready[0]), .m1_awready_o (m_awready[1]), .m2_awready_o (m_awready[2]),
		.m0_awaddr_i (m_awaddr[0]), .m1_awaddr_i (m_awaddr[1]), .m2_awaddr_i (m_awaddr[2]),
		.m0_wvalid_i (m_wvalid[0]), .m1_wvalid_i (m_wvalid[1]), .m2_wvalid_i (m_wvalid[2]),
		.m0_wready_o (m_wready[0]), .m1_wready_o (m_wready[1]), .m2_wready_o (m_wready[2]),
		.m0_wdata_i (m_wdata[0]), .m1_wdata_i (m_wdata[1]), .m2_wdata_i (m_wdata[2]),
		.m0_wstrb_i (m_wstrb[0]), .m1_wstrb_i (m_wstrb[1]), .m2_wstrb_i (m_wstrb[2]),
		.m0_bvalid_o (m_bvalid[0]), .m1_bvalid_o (m_bvalid[1]), .m2_bvalid_o (m_bvalid[2]),
		.m0_bready_i (m_bready[0]), .m1_bready_i (m_bready[1]), .m2_bready_i (m_bready[2]),
		.m0_bresp_o (m_bresp[0]), .m1_bresp_o (m_bresp[1]), .m2_bresp_o (m_bresp[2]),
		.s0_awvalid_o (s_awvalid[0]), .s1_awvalid_o (s_awvalid[1]),
		.s2_awvalid_o (s_awvalid[2]), .s3_awvalid_o (s_awvalid[3]),
		.s0_awready_i (s_awready[0]), .s1_awready_i (s_awready[1]),
		.s2_awready_i (s_awready[2]), .s3_awready_i (s_awready[3]),
		.s0_awaddr_o (s_awaddr[0]), .s1_awaddr_o (s_awaddr[1]),
		.s2_awaddr_o (s_awaddr[2]), .s3_awaddr_o (s_awaddr[3]),
		.s0_wvalid_o (s_wvalid[0]), .s1_wvalid_o (s_wvalid[1]),
		.s2_wvalid_o (s_wvalid[2]), .s3_wvalid_o (s_wvalid[3]),
		.s0_wready_i (s_wready[0]), .s1_wready_i (s_wready[1]),
		.s2_wready_i (s_wready[2]), .s3_wready_i (s_wready[3]),
		.s0_wdata_o (s_wdata[0]), .s1_wdata_o (s_wdata[1]),
		.s2_wdata_o (s_wdata[2]), .s3_wdata_o (s_wdata[3]),
		.s0_wstrb_o (s_wstrb[0]), .s1_wstrb_o (s_wstrb[1]),
		.s2_wstrb_o (s_wstrb[2]), .s3_wstrb_o (s_wstrb[3]),
		.s0_bvalid_i (s_bvalid[0]), .s1_bvalid_i (s_bvalid[1]),
		.s2_bvalid_i (s_bvalid[2]), .s3_bvalid_i (s_bvalid[3]),
		.s0_bready_o (s_bready[0]), .s1_bready_o (s_bready[1]),
		.s2_bready_o (s_bready[2]), .s3_bready_o (s_bready[3]),
		.s0_bresp_i (s_bresp[0]), .s1_bresp_i (s_bresp[1]),
		.s2_bresp_i (s_bresp[2]), .s3_bresp_i (s_bresp[3])
	);

	initial
	begin
		ACLK = 1'b0;
		forever #50 ACLK = ~ACLK;
	end

	// Sample mid-cycle where every signal has settled
	always @(negedge ACLK)
	begin
		for (int m = 0; m < xbar_pkg::N_MASTERS; m++)
		begin
			m_aw_hs[m] = m_awvalid[m] && m_awready[m];
			m_w_hs[m] = m_wvalid[m] && m_wready[m];
			m_b_hs[m] = m_bvalid[m] && m_bready[m];
			if (m_bvalid[m])
				bvalid_seen[m] = 1'b1;
			if (m_awready[m])
				awready_seen[m] = 1'b1;
			if (m_wready[m])
				wready_seen[m] = 1'b1;
			if (m_b_hs[m])
			begin
				b_order.push_back(m);
				got_resp[m] = m_bresp[m];
				done[m] = 1'b1;
			end
		end
		for (int s = 0; s < xbar_pkg::N_SLAVES; s++)
		begin
			aw_seen[s] = s_awvalid[s];
			w_seen[s] = s_wvalid[s];
			s_aw_hs[s] = s_awvalid[s] && s_awready[s];
			s_w_hs[s] = s_wvalid[s] && s_wready[s];
			s_b_hs[s] = s_bvalid[s] && s_bready[s];
			if (s_aw_hs[s])
			begin
				aw_cnt[s]++;
				got_addr[s] = s_awaddr[s];
			end
			if (s_w_hs[s])
			begin
				w_cnt[s]++;
				got_data[s] = s_wdata[s];
				got_strb[s] = s_wstrb[s];
			end
			if (s_b_hs[s])
				b_cnt[s]++;
		end
	end

	// Master and slave models update just after the edge
	always @(posedge ACLK)
	begin
		#1;
		for (int m = 0; m < xbar_pkg::N_MASTERS; m++)
		begin
			if (m_aw_hs[m])
				m_awvalid[m] = 1'b0;
			if (m_w_hs[m])
				m_wvalid[m] = 1'b0;
			if (m_b_hs[m])
				m_bready[m] = 1'b0;
			m_b_hs[m] = 1'b0;
		end
		for (int s = 0; s < xbar_pkg::N_SLAVES; s++)
		begin
			// Ready follows valid by one cycle
			s_awready[s] = aw_seen[s] && !s_aw_hs[s];
			s_wready[s] = w_seen[s] && !s_w_hs[s];
			if (s_b_hs[s])
				b_pend[s] = 1'b0;
			if (s_w_hs[s])
				b_pend[s] = 1'b1;
			s_bvalid[s] = b_pend[s] && !hold_b[s];
			s_aw_hs[s] = 1'b0;
			s_w_hs[s] = 1'b0;
			s_b_hs[s] = 1'b0;
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Slave 3 answers with an error, the others with OKAY
	function automatic axi_pkg::resp_e expected_resp(input int s);
		return (s == 3) ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
	endfunction

	function automatic axi_pkg::addr_t slave_addr(input int s);
		axi_pkg::addr_t a;
		a = $random(seed);
		a[31:30] = 2'(s);
		a[1:0] = 2'b00;
		return a;
	endfunction

	task automatic write_start(input int m, input axi_pkg::addr_t a, input axi_pkg::data_t d,
		input axi_pkg::strb_t st);
		m_aw_hs[m] = 1'b0;
		m_w_hs[m] = 1'b0;
		m_b_hs[m] = 1'b0;
		m_awaddr[m] = a;
		m_wdata[m] = d;
		m_wstrb[m] = st;
		done[m] = 1'b0;
		m_awvalid[m] = 1'b1;
		m_wvalid[m] = 1'b1;
		m_bready[m] = 1'b1;
	endtask

	task automatic wait_b(input int m, input string name);
		int n;
		n = 0;
		while (!done[m] && n < 64)
		begin
			@(posedge ACLK);
			#1;
			n++;
		end
		if (!done[m])
		begin
			$display("%s: master %0d got no write response within 64 cycles", name, m);
			errors++;
		end
	endtask

	task automatic wait_slave_data(input int s, input string name);
		int n;
		n = 0;
		while (!b_pend[s] && n < 64)
		begin
			@(posedge ACLK);
			#1;
			n++;
		end
		if (!b_pend[s])
		begin
			$display("%s: slave %0d never accepted write data", name, s);
			errors++;
		end
	endtask

	task automatic clear_stats();
		for (int k = 0; k < xbar_pkg::N_MASTERS; k++)
		begin
			bvalid_seen[k] = 1'b0;
			awready_seen[k] = 1'b0;
			wready_seen[k] = 1'b0;
		end
		for (int k = 0; k < xbar_pkg::N_SLAVES; k++)
		begin
			aw_cnt[k] = 0;
			w_cnt[k] = 0;
			b_cnt[k] = 0;
		end
		b_order.delete();
	endtask

	task automatic routing_all_pairs();
		int e0;
		string name;
		axi_pkg::addr_t a;
		axi_pkg::data_t d;
		axi_pkg::strb_t st;
		e0 = errors;
		for (int m = 0; m < xbar_pkg::N_MASTERS; m++)
		begin
			for (int s = 0; s < xbar_pkg::N_SLAVES; s++)
			begin
				name = $sformatf("routing m%0d s%0d", m, s);
				clear_stats();
				a = slave_addr(s);
				d = $random(seed);
				st = 4'($random(seed));
				write_start(m, a, d, st);
				wait_b(m, name);
				for (int k = 0; k < xbar_pkg::N_SLAVES; k++)
				begin
					check_val(name, (k == s) ? 1 : 0, aw_cnt[k]);
					check_val(name, (k == s) ? 1 : 0, w_cnt[k]);
					check_val(name, (k == s) ? 1 : 0, b_cnt[k]);
				end
				check_val(name, a, got_addr[s]);
				check_val(name, d, got_data[s]);
				check_val(name, 32'(st), 32'(got_strb[s]));
				for (int j = 0; j < xbar_pkg::N_MASTERS; j++)
				begin
					check_val(name, (j == m) ? 1 : 0, 32'(awready_seen[j]));
					check_val(name, (j == m) ? 1 : 0, 32'(wready_seen[j]));
					check_val(name, (j == m) ? 1 : 0, 32'(bvalid_seen[j]));
				end
			end
		end
		$display("routing: %0d errors", errors - e0);
	endtask

	task automatic response_codes();
		int e0;
		int m;
		e0 = errors;
		for (int s = 0; s < xbar_pkg::N_SLAVES; s++)
		begin
			m = s % xbar_pkg::N_MASTERS;
			clear_stats();
			write_start(m, slave_addr(s), $random(seed), 4'hf);
			wait_b(m, "response");
			check_val("response", 32'(expected_resp(s)), 32'(got_resp[m]));
		end
		$display("response: %0d errors", errors - e0);
	endtask

	task automatic priority_order();
		int e0;
		e0 = errors;
		clear_stats();
		for (int m = 0; m < xbar_pkg::N_MASTERS; m++)
			write_start(m, slave_addr(m), $random(seed), 4'hf);
		for (int m = 0; m < xbar_pkg::N_MASTERS; m++)
			wait_b(m, "priority");
		check_val("priority", 3, b_order.size());
		for (int k = 0; k < b_order.size(); k++)
			check_val("priority", k, b_order[k]);
		$display("priority: %0d errors", errors - e0);
	endtask

	task automatic grant_lock();
		int e0;
		e0 = errors;
		clear_stats();
		hold_b[1] = 1'b1;
		write_start(2, slave_addr(1), $random(seed), 4'hf);
		wait_slave_data(1, "lock");
		awready_seen[0] = 1'b0;
		write_start(0, slave_addr(0), $random(seed), 4'hf);
		repeat (5)
		begin
			@(posedge ACLK);
			#1;
		end
		hold_b[1] = 1'b0;
		wait_b(2, "lock");
		check_val("lock", 0, 32'(awready_seen[0]));
		wait_b(0, "lock");
		check_val("lock", 2, b_order.size());
		check_val("lock", 2, b_order[0]);
		check_val("lock", 0, b_order[1]);
		$display("lock: %0d errors", errors - e0);
	endtask

	task automatic stall_timeout();
		int e0;
		e0 = errors;
		clear_stats();
		hold_b[2] = 1'b1;
		write_start(1, slave_addr(2), $random(seed), 4'hf);
		wait_slave_data(2, "timeout");
		write_start(2, slave_addr(0), $random(seed), 4'hf);
		wait_b(2, "timeout");
		check_val("timeout", 0, 32'(bvalid_seen[1]));
		check_val("timeout", 0, 32'(done[1]));
		// Abandon the stalled write on both sides
		m_bready[1] = 1'b0;
		b_pend[2] = 1'b0;
		hold_b[2] = 1'b0;
		$display("timeout: %0d errors", errors - e0);
	endtask

	initial
	begin
		seed = 32'h3eec_c2c5;
		checks = 0;
		errors = 0;
		ARESETn = 1'b0;
		for (int m = 0; m < xbar_pkg::N_MASTERS; m++)
		begin
			m_awvalid[m] = 1'b0;
			m_awaddr[m] = '0;
			m_wvalid[m] = 1'b0;
			m_wdata[m] = '0;
			m_wstrb[m] = '0;
			m_bready[m] = 1'b0;
			m_aw_hs[m] = 1'b0;
			m_w_hs[m] = 1'b0;
			m_b_hs[m] = 1'b0;
			done[m] = 1'b0;
		end
		for (int s = 0; s < xbar_pkg::N_SLAVES; s++)
		begin
			s_awready[s] = 1'b0;
			s_wready[s] = 1'b0;
			s_bvalid[s] = 1'b0;
			s_bresp[s] = expected_resp(s);
			aw_seen[s] = 1'b0;
			w_seen[s] = 1'b0;
			s_aw_hs[s] = 1'b0;
			s_w_hs[s] = 1'b0;
			s_b_hs[s] = 1'b0;
			b_pend[s] = 1'b0;
			hold_b[s] = 1'b0;
		end
		clear_stats();
		repeat (5) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		@(posedge ACLK);
		#1;
		routing_all_pairs();
		response_codes();
		priority_order();
		grant_lock();
		stall_timeout();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- verification/xbar_assertions.sv
`timescale 1ns/1ps

module xbar_assertions (
	input logic ACLK,
	input logic ARESETn,
	input logic s0_awvalid_i,
	input logic s1_awvalid_i,
	input logic s2_awvalid_i,
	input logic s3_awvalid_i,
	input logic s0_wvalid_i,
	input logic s1_wvalid_i,
	input logic s2_wvalid_i,
	input logic s3_wvalid_i,
	input logic m0_bvalid_i,
	input logic m1_bvalid_i,
	input logic m2_bvalid_i
);

	// Only the decoded slave may see an address
	one_slave_aw: assert property (@(posedge ACLK) disable iff (!ARESETn)
		$onehot0({s3_awvalid_i, s2_awvalid_i, s1_awvalid_i, s0_awvalid_i}))
		else $error("more than one slave AWVALID high");

	// Response goes to the granted master only
	one_master_b: assert property (@(posedge ACLK) disable iff (!ARESETn)
		$onehot0({m2_bvalid_i, m1_bvalid_i, m0_bvalid_i}))
		else $error("more than one master BVALID high");

	// Address and data phases never overlap on a slave
	no_aw_w_overlap: assert property (@(posedge ACLK) disable iff (!ARESETn)
		!((s0_awvalid_i && s0_wvalid_i) || (s1_awvalid_i && s1_wvalid_i) ||
		(s2_awvalid_i && s2_wvalid_i) || (s3_awvalid_i && s3_wvalid_i)))
		else $error("slave WVALID together with AWVALID");

endmodule

bind axi_lite_wr_xbar xbar_assertions u_assertions (
	.ACLK         (ACLK),
	.ARESETn      (ARESETn),
	.s0_awvalid_i (s0_awvalid_o),
	.s1_awvalid_i (s1_awvalid_o),
	.s2_awvalid_i (s2_awvalid_o),
	.s3_awvalid_i (s3_awvalid_o),
	.s0_wvalid_i  (s0_wvalid_o),
	.s1_wvalid_i  (s1_wvalid_o),
	.s2_wvalid_i  (s2_wvalid_o),
	.s3_wvalid_i  (s3_wvalid_o),
	.m0_bvalid_i  (m0_bvalid_o),
	.m1_bvalid_i  (m1_bvalid_o),
	.m2_bvalid_i  (m2_bvalid_o)
);

//--- source/axi_lite_wr_xbar.sv
`timescale 1ns/1ps

module axi_lite_wr_xbar (
	input  logic           ACLK,
	input  logic           ARESETn,
	// Master ports
	input  logic           m0_awvalid_i, m1_awvalid_i, m2_awvalid_i,
	output logic           m0_awready_o, m1_awready_o, m2_awready_o,
	input  axi_pkg::addr_t m0_awaddr_i, m1_awaddr_i, m2_awaddr_i,
	input  logic           m0_wvalid_i, m1_wvalid_i, m2_wvalid_i,
	output logic           m0_wready_o, m1_wready_o, m2_wready_o,
	input  axi_pkg::data_t m0_wdata_i, m1_wdata_i, m2_wdata_i,
	input  axi_pkg::strb_t m0_wstrb_i, m1_wstrb_i, m2_wstrb_i,
	output logic           m0_bvalid_o, m1_bvalid_o, m2_bvalid_o,
	input  logic           m0_bready_i, m1_bready_i, m2_bready_i,
	output axi_pkg::resp_e m0_bresp_o, m1_bresp_o, m2_bresp_o,
	// Slave ports
	output logic           s0_awvalid_o, s1_awvalid_o, s2_awvalid_o, s3_awvalid_o,
	input  logic           s0_awready_i, s1_awready_i, s2_awready_i, s3_awready_i,
	output axi_pkg::addr_t s0_awaddr_o, s1_awaddr_o, s2_awaddr_o, s3_awaddr_o,
	output logic           s0_wvalid_o, s1_wvalid_o, s2_wvalid_o, s3_wvalid_o,
	input  logic           s0_wready_i, s1_wready_i, s2_wready_i, s3_wready_i,
	output axi_pkg::data_t s0_wdata_o, s1_wdata_o, s2_wdata_o, s3_wdata_o,
	output axi_pkg::strb_t s0_wstrb_o, s1_wstrb_o, s2_wstrb_o, s3_wstrb_o,
	input  logic           s0_bvalid_i, s1_bvalid_i, s2_bvalid_i, s3_bvalid_i,
	output logic           s0_bready_o, s1_bready_o, s2_bready_o, s3_bready_o,
	input  axi_pkg::resp_e s0_bresp_i, s1_bresp_i, s2_bresp_i, s3_bresp_i
);

	xbar_pkg::master_idx_t grant;
	logic                  grant_valid;
	logic                  idle;
	logic                  aw_en;
	logic                  w_en;
	logic                  b_en;

	logic [xbar_pkg::N_MASTERS-1:0]                 m_awready;
	logic [xbar_pkg::N_MASTERS-1:0]                 m_wready;
	logic [xbar_pkg::N_MASTERS-1:0]                 m_bvalid;
	axi_pkg::resp_e                                 m_bresp [xbar_pkg::N_MASTERS];
	logic [xbar_pkg::N_SLAVES-1:0]                  s_awvalid;
	axi_pkg::addr_t [xbar_pkg::N_SLAVES-1:0]        s_awaddr;
	logic [xbar_pkg::N_SLAVES-1:0]                  s_wvalid;
	axi_pkg::data_t [xbar_pkg::N_SLAVES-1:0]        s_wdata;
	axi_pkg::strb_t [xbar_pkg::N_SLAVES-1:0]        s_wstrb;
	logic [xbar_pkg::N_SLAVES-1:0]                  s_bready;
	axi_pkg::resp_e                                 s_bresp [xbar_pkg::N_SLAVES];

	wr_req_if req_bus ();
	wr_rsp_if rsp_bus ();

	wr_arbiter u_arbiter (
		.ACLK          (ACLK),
		.ARESETn       (ARESETn),
		.req_i         ({m2_awvalid_i, m1_awvalid_i, m0_awvalid_i}),
		.idle_i        (idle),
		.grant_o       (grant),
		.grant_valid_o (grant_valid)
	);

	wr_channel_ctrl u_ctrl (
		.ACLK          (ACLK),
		.ARESETn       (ARESETn),
		.grant_valid_i (grant_valid),
		.req           (req_bus),
		.rsp           (rsp_bus),
		.idle_o        (idle),
		.aw_en_o       (aw_en),
		.w_en_o        (w_en),
		.b_en_o        (b_en)
	);

	master_wr_mux u_mux (
		.grant_i       (grant),
		.grant_valid_i (grant_valid),
		.m_awvalid_i   ({m2_awvalid_i, m1_awvalid_i, m0_awvalid_i}),
		.m_awaddr_i    ({m2_awaddr_i, m1_awaddr_i, m0_awaddr_i}),
		.m_wvalid_i    ({m2_wvalid_i, m1_wvalid_i, m0_wvalid_i}),
		.m_wdata_i     ({m2_wdata_i, m1_wdata_i, m0_wdata_i}),
		.m_wstrb_i     ({m2_wstrb_i, m1_wstrb_i, m0_wstrb_i}),
		.m_bready_i    ({m2_bready_i, m1_bready_i, m0_bready_i}),
		.m_awready_o   (m_awready),
		.m_wready_o    (m_wready),
		.m_bvalid_o    (m_bvalid),
		.m_bresp_o     (m_bresp),
		.req           (req_bus),
		.rsp           (rsp_bus)
	);

	assign s_bresp = '{s0_bresp_i, s1_bresp_i, s2_bresp_i, s3_bresp_i};

	slave_wr_router u_router (
		.req           (req_bus),
		.rsp           (rsp_bus),
		.aw_en_i       (aw_en),
		.w_en_i        (w_en),
		.b_en_i        (b_en),
		.s_awvalid_o   (s_awvalid),
		.s_awaddr_o    (s_awaddr),
		.s_wvalid_o    (s_wvalid),
		.s_wdata_o     (s_wdata),
		.s_wstrb_o     (s_wstrb),
		.s_bready_o    (s_bready),
		.s_awready_i   ({s3_awready_i, s2_awready_i, s1_awready_i, s0_awready_i}),
		.s_wready_i    ({s3_wready_i, s2_wready_i, s1_wready_i, s0_wready_i}),
		.s_bvalid_i    ({s3_bvalid_i, s2_bvalid_i, s1_bvalid_i, s0_bvalid_i}),
		.s_bresp_i     (s_bresp)
	);

	// Master side outputs
	assign {m2_awready_o, m1_awready_o, m0_awready_o} = m_awready;
	assign {m2_wready_o, m1_wready_o, m0_wready_o} = m_wready;
	assign {m2_bvalid_o, m1_bvalid_o, m0_bvalid_o} = m_bvalid;
	assign m0_bresp_o = m_bresp[0];
	assign m1_bresp_o = m_bresp[1];
	assign m2_bresp_o = m_bresp[2];

	// Slave side outputs
	assign {s3_awvalid_o, s2_awvalid_o, s1_awvalid_o, s0_awvalid_o} = s_awvalid;
	assign {s3_awaddr_o, s2_awaddr_o, s1_awaddr_o, s0_awaddr_o} = s_awaddr;
	assign {s3_wvalid_o, s2_wvalid_o, s1_wvalid_o, s0_wvalid_o} = s_wvalid;
	assign {s3_wdata_o, s2_wdata_o, s1_wdata_o, s0_wdata_o} = s_wdata;
	assign {s3_wstrb_o, s2_wstrb_o, s1_wstrb_o, s0_wstrb_o} = s_wstrb;
	assign {s3_bready_o, s2_bready_o, s1_bready_o, s0_bready_o} = s_bready;

endmodule

//--- source/slave_wr_router.sv
`timescale 1ns/1ps

module slave_wr_router (
	wr_req_if.dst                                    req,
	wr_rsp_if.src                                    rsp,
	input  logic                                     aw_en_i,
	input  logic                                     w_en_i,
	input  logic                                     b_en_i,
	output logic [xbar_pkg::N_SLAVES-1:0]            s_awvalid_o,
	output axi_pkg::addr_t [xbar_pkg::N_SLAVES-1:0]  s_awaddr_o,
	output logic [xbar_pkg::N_SLAVES-1:0]            s_wvalid_o,
	output axi_pkg::data_t [xbar_pkg::N_SLAVES-1:0]  s_wdata_o,
	output axi_pkg::strb_t [xbar_pkg::N_SLAVES-1:0]  s_wstrb_o,
	output logic [xbar_pkg::N_SLAVES-1:0]            s_bready_o,
	input  logic [xbar_pkg::N_SLAVES-1:0]            s_awready_i,
	input  logic [xbar_pkg::N_SLAVES-1:0]            s_wready_i,
	input  logic [xbar_pkg::N_SLAVES-1:0]            s_bvalid_i,
	input  axi_pkg::resp_e                           s_bresp_i [xbar_pkg::N_SLAVES]
);

	xbar_pkg::slave_idx_t sel;

	// Decoded from the live address, so the master holds AWADDR until B
	assign sel = req.awaddr[xbar_pkg::SLAVE_SEL_LSB +: $bits(xbar_pkg::slave_idx_t)];

	always_comb
	begin
		for (int k = 0; k < xbar_pkg::N_SLAVES; k++)
		begin
			s_awvalid_o[k] = 1'b0;
			s_awaddr_o[k] = '0;
			s_wvalid_o[k] = 1'b0;
			s_wdata_o[k] = '0;
			s_wstrb_o[k] = '0;
			s_bready_o[k] = 1'b0;
			if (sel == xbar_pkg::slave_idx_t'(k))
			begin
				s_awvalid_o[k] = aw_en_i & req.awvalid;
				s_awaddr_o[k] = req.awaddr;
				s_wvalid_o[k] = w_en_i & req.wvalid;
				s_wdata_o[k] = req.wdata;
				s_wstrb_o[k] = req.wstrb;
				s_bready_o[k] = b_en_i & req.bready;
			end
		end
	end

	// Readies outside their phase would complete a handshake the FSM does not expect
	assign rsp.awready = aw_en_i & s_awready_i[sel];
	assign rsp.wready = w_en_i & s_wready_i[sel];
	assign rsp.bvalid = b_en_i & s_bvalid_i[sel];
	assign rsp.bresp = s_bresp_i[sel];

endmodule

//--- source/master_wr_mux.sv
`timescale 1ns/1ps

module master_wr_mux (
	input  xbar_pkg::master_idx_t                           grant_i,
	input  logic                                            grant_valid_i,
	input  logic [xbar_pkg::N_MASTERS-1:0]                  m_awvalid_i,
	input  axi_pkg::addr_t [xbar_pkg::N_MASTERS-1:0]        m_awaddr_i,
	input  logic [xbar_pkg::N_MASTERS-1:0]                  m_wvalid_i,
	input  axi_pkg::data_t [xbar_pkg::N_MASTERS-1:0]        m_wdata_i,
	input  axi_pkg::strb_t [xbar_pkg::N_MASTERS-1:0]        m_wstrb_i,
	input  logic [xbar_pkg::N_MASTERS-1:0]                  m_bready_i,
	output logic [xbar_pkg::N_MASTERS-1:0]                  m_awready_o,
	output logic [xbar_pkg::N_MASTERS-1:0]                  m_wready_o,
	output logic [xbar_pkg::N_MASTERS-1:0]                  m_bvalid_o,
	output axi_pkg::resp_e                                  m_bresp_o [xbar_pkg::N_MASTERS],
	wr_req_if.src                                           req,
	wr_rsp_if.dst                                           rsp
);

	logic [xbar_pkg::N_MASTERS-1:0] sel;

	// One-hot of the granted master or zero without a grant
	always_comb
	begin
		for (int k = 0; k < xbar_pkg::N_MASTERS; k++)
		begin
			sel[k] = grant_valid_i && (grant_i == xbar_pkg::master_idx_t'(k));
		end
	end

	always_comb
	begin
		req.awvalid = 1'b0;
		req.awaddr = '0;
		req.wvalid = 1'b0;
		req.wdata = '0;
		req.wstrb = '0;
		req.bready = 1'b0;
		for (int k = 0; k < xbar_pkg::N_MASTERS; k++)
		begin
			m_awready_o[k] = 1'b0;
			m_wready_o[k] = 1'b0;
			m_bvalid_o[k] = 1'b0;
			m_bresp_o[k] = axi_pkg::RESP_OKAY;
			if (sel[k])
			begin
				req.awvalid = m_awvalid_i[k];
				req.awaddr = m_awaddr_i[k];
				req.wvalid = m_wvalid_i[k];
				req.wdata = m_wdata_i[k];
				req.wstrb = m_wstrb_i[k];
				req.bready = m_bready_i[k];
				// Only the owner of the grant sees the slave's answers
				m_awready_o[k] = rsp.awready;
				m_wready_o[k] = rsp.wready;
				m_bvalid_o[k] = rsp.bvalid;
				m_bresp_o[k] = rsp.bresp;
			end
		end
	end

endmodule

//--- source/wr_channel_ctrl.sv
`timescale 1ns/1ps

module wr_channel_ctrl (
	input  logic  ACLK,
	input  logic  ARESETn,
	input  logic  grant_valid_i,
	wr_req_if.mon req,
	wr_rsp_if.mon rsp,
	output logic  idle_o,
	output logic  aw_en_o,
	output logic  w_en_o,
	output logic  b_en_o
);

	xbar_pkg::wr_state_e state;
	xbar_pkg::wr_state_e state_nxt;
	xbar_pkg::tmo_cnt_t  tmo_cnt;
	logic                timeout;
	logic                aw_hs;
	logic                w_hs;
	logic                b_hs;

	// Readies from the router are already phase gated
	assign aw_hs = req.awvalid & rsp.awready;
	assign w_hs = req.wvalid & rsp.wready;
	assign b_hs = rsp.bvalid & req.bready;

	assign timeout = (tmo_cnt == xbar_pkg::tmo_cnt_t'(xbar_pkg::TIMEOUT_CYCLES));

	always_comb
	begin
		state_nxt = state;
		case (state)
			xbar_pkg::WR_IDLE:
			begin
				if (grant_valid_i)
				begin
					state_nxt = aw_hs ? xbar_pkg::WR_DATA : xbar_pkg::WR_ADDR;
				end
			end
			xbar_pkg::WR_ADDR:
			begin
				if (aw_hs)
				begin
					state_nxt = xbar_pkg::WR_DATA;
				end
			end
			xbar_pkg::WR_DATA:
			begin
				if (w_hs)
				begin
					state_nxt = xbar_pkg::WR_RESP;
				end
			end
			xbar_pkg::WR_RESP:
			begin
				if (b_hs)
				begin
					state_nxt = xbar_pkg::WR_IDLE;
				end
			end
			default:
			begin
				state_nxt = xbar_pkg::WR_IDLE;
			end
		endcase
		// Stalled transfer is abandoned without a response
		if (timeout)
		begin
			state_nxt = xbar_pkg::WR_IDLE;
		end
	end

	always_ff @(posedge ACLK or negedge ARESETn)
	begin
		if (!ARESETn)
		begin
			state <= xbar_pkg::WR_IDLE;
			tmo_cnt <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (idle_o || timeout)
			begin
				tmo_cnt <= '0;
			end
			else
			begin
				tmo_cnt <= tmo_cnt + 1'b1;
			end
		end
	end

	assign idle_o = (state == xbar_pkg::WR_IDLE);

	// One phase open at a time
	assign aw_en_o = (idle_o && grant_valid_i) || (state == xbar_pkg::WR_ADDR);
	assign w_en_o = (state == xbar_pkg::WR_DATA);
	assign b_en_o = (state == xbar_pkg::WR_RESP);

endmodule

//--- source/wr_arbiter.sv
`timescale 1ns/1ps

module wr_arbiter (
	input  logic                           ACLK,
	input  logic                           ARESETn,
	input  logic [xbar_pkg::N_MASTERS-1:0] req_i,
	input  logic                           idle_i,
	output xbar_pkg::master_idx_t          grant_o,
	output logic                           grant_valid_o
);

	xbar_pkg::master_idx_t pick;
	logic                  pick_valid;
	xbar_pkg::master_idx_t grant_r;
	logic                  grant_valid_r;

	// Fixed priority, lowest index wins
	always_comb
	begin
		pick = '0;
		pick_valid = 1'b0;
		for (int k = xbar_pkg::N_MASTERS - 1; k >= 0; k--)
		begin
			if (req_i[k])
			begin
				pick = xbar_pkg::master_idx_t'(k);
				pick_valid = 1'b1;
			end
		end
	end

	// Choice is sampled only while idle, then frozen for the transfer
	always_ff @(posedge ACLK or negedge ARESETn)
	begin
		if (!ARESETn)
		begin
			grant_r <= '0;
			grant_valid_r <= 1'b0;
		end
		else if (idle_i)
		begin
			grant_r <= pick;
			grant_valid_r <= pick_valid;
		end
	end

	// Live pick in idle so the AW handshake can finish in the first cycle
	assign grant_o = idle_i ? pick : grant_r;
	assign grant_valid_o = idle_i ? pick_valid : grant_valid_r;

endmodule

//--- source/axi_wr_if.sv
`timescale 1ns/1ps

// Granted write request, master side to slave side
interface wr_req_if;
	logic           awvalid;
	axi_pkg::addr_t awaddr;
	logic           wvalid;
	axi_pkg::data_t wdata;
	axi_pkg::strb_t wstrb;
	logic           bready;

	modport src (output awvalid, awaddr, wvalid, wdata, wstrb, bready);
	modport dst (input awvalid, awaddr, wvalid, wdata, wstrb, bready);
	modport mon (input awvalid, awaddr, wvalid, wdata, wstrb, bready);
endinterface

// Response of the decoded slave, already gated by phase
interface wr_rsp_if;
	logic           awready;
	logic           wready;
	logic           bvalid;
	axi_pkg::resp_e bresp;

	modport src (output awready, wready, bvalid, bresp);
	modport dst (input awready, wready, bvalid, bresp);
	modport mon (input awready, wready, bvalid, bresp);
endinterface

//--- source/xbar_pkg.sv
package xbar_pkg;

	// Port counts
	localparam int N_MASTERS = 3;
	localparam int N_SLAVES  = 4;

	typedef logic [1:0] master_idx_t;
	typedef logic [1:0] slave_idx_t;

	// Slave k owns the k-th quarter of the address space
	localparam int SLAVE_SEL_LSB = 30;

	// Non-idle cycles before the channel is forced back to idle
	localparam int TIMEOUT_CYCLES = 15;

	typedef logic [3:0] tmo_cnt_t;

	// Write channel phases
	typedef enum logic [1:0]
	{
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

endpackage

//--- source/axi_pkg.sv
package axi_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;

	// Write response codes in AXI encoding
	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

endpackage
